// ==== vlog.f ====
+incdir+common
common/decoder_msg_pkg.sv
common/decoder_ctrl_pkg.sv
logic/msg_fifo.sv
logic/credit_tx.sv
root_hub/root_hub_ctrl.sv
root_hub/root_hub_regs.sv
logic/root_hub_top.sv
verification/root_hub_chk.sv
verification/root_hub_tb.sv

// ==== verification/root_hub_tb.sv ====
`timescale 1ns/100ps

`include "decoder_config.svh"

module root_hub_tb;

    import decoder_msg_pkg::*;
    import decoder_ctrl_pkg::*;

    localparam int ROW_COUNT      = 5;
    localparam int TIMEOUT_CYCLES = 300;
    localparam int POLL_LIMIT     = 100;
    localparam int QUIET_CYCLES   = 60;
    localparam int HOLD_START     = 1; // downstream credits of rounds 1 and 2 are withheld.
    localparam int HOLD_END       = 3;

    typedef struct packed {
        context_t   ctx;
        payload_t   payload;
        logic [1:0] junk;
        logic       clear;
    } row_t;

    logic       clk;
    logic       reset;
    logic       cfg_write;
    logic       cfg_read;
    reg_addr_t  cfg_addr;
    reg_data_t  cfg_wdata;
    reg_data_t  cfg_rdata;
    logic       cfg_rvalid;
    link_word_t down_data;
    logic       down_valid;
    logic       down_credit;
    link_word_t up_data;
    logic       up_valid;
    logic       up_credit;

    row_t        rows [ROW_COUNT];
    link_word_t  rx_words [$];
    int          credit_due [$];
    int          cycle = 0;
    int          down_sent = 0;
    int          down_returned = 0;
    int          up_sent = 0;
    int          up_returned = 0;
    int          errors = 0;
    int          checks = 0;
    bit          timed_out = 0;
    logic        hold_credits;
    logic [31:0] lcg_state = 32'd88352;

    root_hub_top root_hub_top_inst (.*);

    bind root_hub_top root_hub_chk chk_inst (
        .clk         (clk),
        .reset       (reset),
        .credit_cnt  (credit_tx_inst.credit_cnt),
        .down_valid  (down_valid),
        .down_credit (down_credit),
        .up_valid    (up_valid),
        .fifo_count  (msg_fifo_inst.count),
        .cfg_read    (cfg_read),
        .cfg_rvalid  (cfg_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // control words from the hub are broadcast with an empty payload.
    function automatic link_word_t expected_down(input msg_type_t kind, input context_t ctx);
        return {node_id_t'(`BROADCAST_ID), node_id_t'(`FPGA_ID), kind, ctx, payload_t'(0)};
    endfunction

    // downstream receiver with randomly delayed credit return.
    always @(posedge clk) begin
        down_credit <= 1'b0;
        if (down_valid === 1'b1) begin
            rx_words.push_back(down_data);
            lcg_state = lcg_next(lcg_state);
            credit_due.push_back(cycle + int'(lcg_state[30:16]) % 6);
            down_sent++;
        end
        if (!hold_credits && credit_due.size() > 0 && credit_due[0] <= cycle) begin
            void'(credit_due.pop_front());
            down_credit <= 1'b1;
            down_returned++;
        end
        if (down_sent - down_returned > `DOWN_CREDITS) begin
            $display("at %0t more downstream words are outstanding than credits allow", $time);
            errors++;
        end
        cycle++;
    end

    always @(posedge clk) begin
        if (up_credit === 1'b1) begin
            up_returned++;
        end
    end

    task automatic report_timeout(input string what);
        $display("at %0t timed out waiting for %s", $time, what);
        errors++;
        timed_out = 1;
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input link_word_t got, input link_word_t exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input reg_data_t got, input reg_data_t exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        @(posedge clk);
        cfg_write <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_write <= 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
        int n;
        data = 'x;
        @(posedge clk);
        cfg_read <= 1'b1;
        cfg_addr <= addr;
        @(posedge clk);
        cfg_read <= 1'b0;
        @(posedge clk);
        n = 1;
        while (cfg_rvalid !== 1'b1 && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (cfg_rvalid === 1'b1) begin
            data = cfg_rdata;
        end else begin
            report_timeout("a register read response");
        end
    endtask

    // the sender holds back while all of its credits are in use.
    task automatic send_up(input link_word_t word);
        int n;
        n = 0;
        while (up_sent - up_returned >= `UP_FIFO_DEPTH && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (up_sent - up_returned >= `UP_FIFO_DEPTH) begin
            report_timeout("an upstream credit");
        end else begin
            @(posedge clk);
            up_valid <= 1'b1;
            up_data  <= word;
            up_sent++;
            @(posedge clk);
            up_valid <= 1'b0;
        end
    endtask

    task automatic wait_down_words(input int count);
        int n;
        n = 0;
        while (rx_words.size() < count && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (rx_words.size() < count) begin
            report_timeout("downstream words");
        end
    endtask

    task automatic wait_rounds(input int target, output reg_data_t value);
        int n;
        n = 0;
        value = '0;
        while (n < POLL_LIMIT && !timed_out) begin
            reg_read(ROUNDS, value);
            if (value[15:0] == target[15:0]) begin
                break;
            end
            n++;
        end
        if (n == POLL_LIMIT) begin
            report_timeout("the rounds count to increase");
        end
    endtask

    task automatic wait_up_credits();
        int n;
        n = 0;
        while (up_returned < up_sent && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (up_returned < up_sent) begin
            report_timeout("upstream credits to return");
        end
    endtask

    initial begin
        int        i;
        int        j;
        int        row_errors;
        int        exp_rounds;
        int        exp_dropped;
        bit        enabled;
        reg_data_t rd;
        link_word_t word;
        reset        = 1'b1;
        cfg_write    = 1'b0;
        cfg_read     = 1'b0;
        cfg_addr     = CTRL;
        cfg_wdata    = '0;
        down_credit  = 1'b0;
        up_data      = '0;
        up_valid     = 1'b0;
        hold_credits = 1'b0;
        exp_rounds   = 0;
        exp_dropped  = 0;
        enabled      = 0;

        // context, result payload, junk words before the result, clear enable after.
        rows[0] = '{8'h11, 32'hcafe_0001, 2'd0, 1'b0};
        rows[1] = '{8'h22, 32'h0bad_f00d, 2'd2, 1'b0};
        rows[2] = '{8'h33, 32'h1234_5678, 2'd1, 1'b0};
        rows[3] = '{8'h44, 32'h8765_4321, 2'd1, 1'b1};
        rows[4] = '{8'h55, 32'hdead_beef, 2'd2, 1'b1};

        for (i = 0; i < 8; i++) begin
            @(posedge clk);
            if (i > 0) begin
                check_bit("down_valid", down_valid, 1'b0);
                check_bit("up_credit", up_credit, 1'b0);
            end
        end
        reset <= 1'b0;
        for (i = 0; i < 2; i++) begin
            @(posedge clk);
            check_bit("down_valid", down_valid, 1'b0);
            check_bit("up_credit", up_credit, 1'b0);
        end
        reg_read(CTRL, rd);
        check_reg("CTRL", rd, '0);
        reg_read(CONTEXT, rd);
        check_reg("CONTEXT", rd, '0);
        reg_read(ROUNDS, rd);
        check_reg("ROUNDS", rd, '0);
        reg_read(decoder_ctrl_pkg::RESULT, rd);
        check_reg("RESULT", rd, '0);

        for (i = 0; i < ROW_COUNT && !timed_out; i++) begin
            row_errors = errors;
            if (i == HOLD_END) begin
                hold_credits <= 1'b0;
            end
            if (!enabled) begin
                reg_write(CONTEXT, reg_data_t'(rows[i].ctx));
                reg_write(CTRL, 32'd1);
                enabled = 1;
            end
            wait_down_words(2);
            if (!timed_out) begin
                word = rx_words.pop_front();
                check_word("down_data", word, expected_down(START_DECODING, rows[i].ctx));
                word = rx_words.pop_front();
                check_word("down_data", word, expected_down(MEASUREMENT_HEADER, rows[i].ctx));
            end
            for (j = 0; j < rows[i].junk; j++) begin
                send_up({node_id_t'(`FPGA_ID), 8'h20, MEASUREMENT_HEADER, rows[i].ctx,
                         payload_t'(j)});
            end
            // the next round starts right after the result, so its context goes in first.
            if (rows[i].clear) begin
                reg_write(CTRL, 32'd0);
                enabled = 0;
            end else if (i + 1 < ROW_COUNT) begin
                reg_write(CONTEXT, reg_data_t'(rows[i + 1].ctx));
            end
            if (i + 1 >= HOLD_START && i + 1 < HOLD_END) begin
                hold_credits <= 1'b1;
            end
            send_up({node_id_t'(`FPGA_ID), 8'h20, decoder_msg_pkg::RESULT, rows[i].ctx,
                     rows[i].payload});
            exp_rounds++;
            exp_dropped += rows[i].junk;
            wait_rounds(exp_rounds, rd);
            check_reg("ROUNDS", rd, {exp_dropped[15:0], exp_rounds[15:0]});
            reg_read(decoder_ctrl_pkg::RESULT, rd);
            check_reg("RESULT", rd, rows[i].payload);
            wait_up_credits();
            check_reg("up_credit pulses", reg_data_t'(up_returned), reg_data_t'(up_sent));
            if (rows[i].clear && !timed_out) begin
                repeat (QUIET_CYCLES) @(posedge clk);
                if (rx_words.size() != 0) begin
                    $display("at %0t downstream words appeared while disabled", $time);
                    errors++;
                end
                reg_read(ROUNDS, rd);
                check_reg("ROUNDS", rd, {exp_dropped[15:0], exp_rounds[15:0]});
            end
            $display("row %0d: context %h, %0d junk word(s), %0d new error(s)",
                     i, rows[i].ctx, rows[i].junk, errors - row_errors);
        end

        $display("%0d rows, %0d checks, %0d errors", i, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== verification/root_hub_chk.sv ====
`timescale 1ns/100ps

`include "decoder_config.svh"

module root_hub_chk (
    input logic                                   clk,
    input logic                                   reset,
    input logic [$clog2(`DOWN_CREDITS + 1)-1:0]   credit_cnt,
    input logic                                   down_valid,
    input logic                                   down_credit,
    input logic                                   up_valid,
    input logic [$clog2(`UP_FIFO_DEPTH + 1)-1:0]  fifo_count,
    input logic                                   cfg_read,
    input logic                                   cfg_rvalid
);

    localparam int CNT_W = $clog2(`DOWN_CREDITS + 1);

    logic [CNT_W-1:0] link_credits; // receiver room as seen from the link pins.

    always_ff @(posedge clk) begin
        if (reset) begin
            link_credits <= CNT_W'(`DOWN_CREDITS);
        end else begin
            link_credits <= link_credits - down_valid + down_credit;
        end
    end

    // the credit counter starts full and can only be refilled by returned credits.
    credit_limit: assert property (@(posedge clk) disable iff (reset)
        credit_cnt <= `DOWN_CREDITS)
        else $error("downstream credit count above its limit");

    // every word on the link found room at the receiver.
    send_with_credit: assert property (@(posedge clk) disable iff (reset)
        down_valid |-> link_credits != '0)
        else $error("downstream word sent with no credit left");

    fifo_room: assert property (@(posedge clk) disable iff (reset)
        up_valid |-> fifo_count < `UP_FIFO_DEPTH)
        else $error("receive FIFO written while full");

    read_response: assert property (@(posedge clk) disable iff (reset)
        cfg_read |=> cfg_rvalid)
        else $error("register read got no response in the next cycle");

    read_no_extra: assert property (@(posedge clk) disable iff (reset)
        cfg_rvalid |-> $past(cfg_read))
        else $error("register read response without a read request");

endmodule

// ==== logic/root_hub_top.sv ====
`timescale 1ns/100ps

`include "decoder_config.svh"

module root_hub_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cfg_write,
    input  logic                       cfg_read,
    input  decoder_ctrl_pkg::reg_addr_t cfg_addr,
    input  decoder_ctrl_pkg::reg_data_t cfg_wdata,
    output decoder_ctrl_pkg::reg_data_t cfg_rdata,
    output logic                       cfg_rvalid,
    output decoder_msg_pkg::link_word_t down_data,
    output logic                       down_valid,
    input  logic                       down_credit,
    input  decoder_msg_pkg::link_word_t up_data,
    input  logic                       up_valid,
    output logic                       up_credit
);

    import decoder_msg_pkg::*;

    logic       enable;
    context_t   context_id;
    logic       round_done;
    payload_t   result_payload;
    logic       word_dropped;
    link_word_t msg_data;
    logic       msg_valid;
    logic       msg_accept;
    link_word_t fifo_data;
    logic       fifo_empty;
    logic       fifo_pop;

    root_hub_regs regs_inst (
        .clk            (clk),
        .reset          (reset),
        .cfg_write      (cfg_write),
        .cfg_read       (cfg_read),
        .cfg_addr       (cfg_addr),
        .cfg_wdata      (cfg_wdata),
        .cfg_rdata      (cfg_rdata),
        .cfg_rvalid     (cfg_rvalid),
        .enable         (enable),
        .context_id     (context_id),
        .round_done     (round_done),
        .result_payload (result_payload),
        .word_dropped   (word_dropped)
    );

    root_hub_ctrl ctrl_inst (
        .clk            (clk),
        .reset          (reset),
        .enable         (enable),
        .context_id     (context_id),
        .msg_data       (msg_data),
        .msg_valid      (msg_valid),
        .msg_accept     (msg_accept),
        .fifo_data      (fifo_data),
        .fifo_empty     (fifo_empty),
        .fifo_pop       (fifo_pop),
        .round_done     (round_done),
        .result_payload (result_payload),
        .word_dropped   (word_dropped)
    );

    msg_fifo #(
        .DEPTH (`UP_FIFO_DEPTH)
    ) msg_fifo_inst (
        .clk        (clk),
        .reset      (reset),
        .up_data    (up_data),
        .up_valid   (up_valid),
        .up_credit  (up_credit),
        .fifo_data  (fifo_data),
        .fifo_empty (fifo_empty),
        .fifo_pop   (fifo_pop)
    );

    credit_tx #(
        .CREDITS (`DOWN_CREDITS)
    ) credit_tx_inst (
        .clk         (clk),
        .reset       (reset),
        .msg_data    (msg_data),
        .msg_valid   (msg_valid),
        .msg_accept  (msg_accept),
        .down_data   (down_data),
        .down_valid  (down_valid),
        .down_credit (down_credit)
    );

endmodule

// ==== root_hub/root_hub_regs.sv ====
`timescale 1ns/100ps

module root_hub_regs (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cfg_write,
    input  logic                       cfg_read,
    input  decoder_ctrl_pkg::reg_addr_t cfg_addr,
    input  decoder_ctrl_pkg::reg_data_t cfg_wdata,
    output decoder_ctrl_pkg::reg_data_t cfg_rdata,
    output logic                       cfg_rvalid,
    output logic                       enable,
    output decoder_msg_pkg::context_t   context_id,
    input  logic                       round_done,
    input  decoder_msg_pkg::payload_t   result_payload,
    input  logic                       word_dropped
);

    import decoder_ctrl_pkg::*;

    count_t    rounds_done;
    count_t    dropped_words;
    reg_data_t last_result;
    reg_data_t read_mux;

    always_comb begin
        unique case (cfg_addr)
            CTRL:    read_mux = {31'b0, enable};
            CONTEXT: read_mux = {24'b0, context_id};
            ROUNDS:  read_mux = {dropped_words, rounds_done};
            RESULT:  read_mux = last_result;
            default: read_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            enable        <= 1'b0;
            context_id    <= '0;
            rounds_done   <= '0;
            dropped_words <= '0;
            last_result   <= '0;
            cfg_rdata     <= '0;
            cfg_rvalid    <= 1'b0;
        end else begin
            // ROUNDS and RESULT are status only, so writes there have no effect.
            if (cfg_write) begin
                case (cfg_addr)
                    CTRL:    enable <= cfg_wdata[0];
                    CONTEXT: context_id <= cfg_wdata[7:0];
                    default: ;
                endcase
            end

            if (round_done) begin
                rounds_done <= rounds_done + 1'b1;
                last_result <= result_payload;
            end

            if (word_dropped) begin
                dropped_words <= dropped_words + 1'b1;
            end

            cfg_rvalid <= cfg_read; // read data follows the request by one cycle.
            if (cfg_read) begin
                cfg_rdata <= read_mux;
            end
        end
    end

endmodule

// ==== root_hub/root_hub_ctrl.sv ====
`timescale 1ns/100ps

`include "decoder_config.svh"

module root_hub_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       enable,
    input  decoder_msg_pkg::context_t   context_id,
    output decoder_msg_pkg::link_word_t msg_data,
    output logic                       msg_valid,
    input  logic                       msg_accept,
    input  decoder_msg_pkg::link_word_t fifo_data,
    input  logic                       fifo_empty,
    output logic                       fifo_pop,
    output logic                       round_done,
    output decoder_msg_pkg::payload_t   result_payload,
    output logic                       word_dropped
);

    import decoder_msg_pkg::*;
    import decoder_ctrl_pkg::*;

    hub_state_t state;
    hub_state_t state_next;
    msg_type_t  tx_type;
    msg_type_t  rx_type;
    logic       rx_is_result;

    // type of the word at the head of the receive FIFO.
    assign rx_type      = msg_type_t'(fifo_data[47:40]);
    assign rx_is_result = (rx_type == decoder_msg_pkg::RESULT);

    assign tx_type = (state == SEND_HEADER) ? MEASUREMENT_HEADER : START_DECODING;

    // downstream control words carry no payload.
    assign msg_data = {node_id_t'(`BROADCAST_ID), node_id_t'(`FPGA_ID), tx_type,
                       context_id, payload_t'(0)};

    assign msg_valid = (state == SEND_START) || (state == SEND_HEADER);

    assign fifo_pop       = (state == WAIT_RESULT) && !fifo_empty;
    assign round_done     = fifo_pop && rx_is_result;
    assign word_dropped   = fifo_pop && !rx_is_result;
    assign result_payload = fifo_data[31:0]; // only meaningful with round_done.

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE: begin
                if (enable) begin
                    state_next = SEND_START;
                end
            end
            SEND_START: begin
                if (msg_accept) begin
                    state_next = SEND_HEADER;
                end
            end
            SEND_HEADER: begin
                if (msg_accept) begin
                    state_next = WAIT_RESULT;
                end
            end
            WAIT_RESULT: begin
                // back through IDLE, where enable decides whether another round starts.
                if (round_done) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== logic/credit_tx.sv ====
`timescale 1ns/100ps

`include "decoder_config.svh"

module credit_tx #(
    parameter int CREDITS = `DOWN_CREDITS
) (
    input  logic                       clk,
    input  logic                       reset,
    input  decoder_msg_pkg::link_word_t msg_data,
    input  logic                       msg_valid,
    output logic                       msg_accept,
    output decoder_msg_pkg::link_word_t down_data,
    output logic                       down_valid,
    input  logic                       down_credit
);

    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;

    // a word goes out only while the receiver has room for it.
    assign msg_accept = msg_valid && (credit_cnt != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= CNT_W'(CREDITS);
            down_valid <= 1'b0;
        end else begin
            down_valid <= msg_accept;

            // a send and a return in the same cycle cancel out.
            case ({msg_accept, down_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (msg_accept) begin
            down_data <= msg_data;
        end
    end

endmodule

// ==== logic/msg_fifo.sv ====
`timescale 1ns/100ps

`include "decoder_config.svh"

module msg_fifo #(
    parameter int DEPTH = `UP_FIFO_DEPTH
) (
    input  logic                       clk,
    input  logic                       reset,
    input  decoder_msg_pkg::link_word_t up_data,
    input  logic                       up_valid,
    output logic                       up_credit,
    output decoder_msg_pkg::link_word_t fifo_data,
    output logic                       fifo_empty,
    input  logic                       fifo_pop
);

    import decoder_msg_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    link_word_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             do_pop;

    // the sender only sends with credit, so there is always room for a write.
    assign push   = up_valid;
    assign do_pop = fifo_pop && !fifo_empty;

    assign fifo_empty = (count == '0);
    assign fifo_data  = mem[rd_ptr]; // head of queue, visible the cycle after the write.

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= up_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            up_credit <= 1'b0;
        end else begin
            up_credit <= do_pop; // one credit back to the sender per word popped.

            if (push) begin
                if (wr_ptr == PTR_W'(DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end

            if (do_pop) begin
                if (rd_ptr == PTR_W'(DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end

            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== common/decoder_ctrl_pkg.sv ====
package decoder_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE,
        SEND_START,
        SEND_HEADER,
        WAIT_RESULT
    } hub_state_t;

    typedef enum logic [1:0] {
        CTRL    = 2'd0,
        CONTEXT = 2'd1,
        ROUNDS  = 2'd2,
        RESULT  = 2'd3
    } reg_addr_t;

    typedef logic [31:0] reg_data_t;

    // each half of the ROUNDS register.
    typedef logic [15:0] count_t;

endpackage

// ==== common/decoder_msg_pkg.sv ====
package decoder_msg_pkg;

`include "decoder_config.svh"

    // byte 7 destination, byte 6 source, byte 5 type, byte 4 context, bytes 3..0 payload.
    typedef logic [`LINK_WIDTH-1:0] link_word_t;

    typedef logic [7:0] node_id_t;
    typedef logic [7:0] context_t;
    typedef logic [31:0] payload_t;

    typedef enum logic [7:0] {
        START_DECODING     = 8'd1,
        MEASUREMENT_HEADER = 8'd2,
        RESULT             = 8'd3
    } msg_type_t;

endpackage

// ==== common/decoder_config.svh ====
`ifndef DECODER_CONFIG_SVH
`define DECODER_CONFIG_SVH

// width of one word on either link.
`define LINK_WIDTH 64

// receive FIFO depth, equal to the upstream sender's starting credits.
`define UP_FIFO_DEPTH 16

// words the downstream receiver can buffer.
`define DOWN_CREDITS 4

`define FPGA_ID 1
`define BROADCAST_ID 8'hFF

`endif
